// ==== verilog/csr_pkg.sv ====
package csr_pkg;

   localparam int xlen_p        = 64;
   localparam int vaddr_width_p = 39;

   typedef logic [11:0] csr_addr_t;

   localparam csr_addr_t csr_mstatus_c       = 12'h300;
   localparam csr_addr_t csr_misa_c          = 12'h301;
   localparam csr_addr_t csr_mie_c           = 12'h304;
   localparam csr_addr_t csr_mtvec_c         = 12'h305;
   localparam csr_addr_t csr_mcountinhibit_c = 12'h320;
   localparam csr_addr_t csr_mscratch_c      = 12'h340;
   localparam csr_addr_t csr_mepc_c          = 12'h341;
   localparam csr_addr_t csr_mcause_c        = 12'h342;
   localparam csr_addr_t csr_mtval_c         = 12'h343;
   localparam csr_addr_t csr_mip_c           = 12'h344;
   localparam csr_addr_t csr_mcycle_c        = 12'hb00;
   localparam csr_addr_t csr_minstret_c      = 12'hb02;
   localparam csr_addr_t csr_mvendorid_c     = 12'hf11;
   localparam csr_addr_t csr_marchid_c       = 12'hf12;
   localparam csr_addr_t csr_mimpid_c        = 12'hf13;
   localparam csr_addr_t csr_mhartid_c       = 12'hf14;

   typedef enum logic [1:0] {
      priv_u = 2'b00,
      priv_m = 2'b11
   } priv_e;

   typedef enum logic [3:0] {
      op_rw       = 4'd0,
      op_rs       = 4'd1,
      op_rc       = 4'd2,
      op_rwi      = 4'd3,
      op_rsi      = 4'd4,
      op_rci      = 4'd5,
      op_mret     = 4'd6,
      op_take_irq = 4'd7
   } csr_op_e;

   typedef enum logic [1:0] {
      kind_access,
      kind_mret,
      kind_irq,
      kind_none
   } cmd_kind_e;

   // Bit n set means exception cause n
   typedef logic [15:0] ecode_dec_t;

   typedef struct packed {
      logic [50:0] wpri_13;
      priv_e       mpp;
      logic [2:0]  wpri_8;
      logic        mpie;
      logic [2:0]  wpri_4;
      logic        mie;
      logic [2:0]  wpri_0;
   } mstatus_t;

   typedef struct packed {
      logic [51:0] wpri_12;
      logic        meie;
      logic [2:0]  wpri_8;
      logic        mtie;
      logic [2:0]  wpri_4;
      logic        msie;
      logic [2:0]  wpri_0;
   } mie_t;

   typedef struct packed {
      logic [51:0] wpri_12;
      logic        meip;
      logic [2:0]  wpri_8;
      logic        mtip;
      logic [2:0]  wpri_4;
      logic        msip;
      logic [2:0]  wpri_0;
   } mip_t;

   typedef struct packed {
      logic        interrupt;
      logic [58:0] wlrl_4;
      logic [3:0]  ecode;
   } mcause_t;

   typedef struct packed {
      logic [60:0] wpri_3;
      logic        ir;
      logic        tm;
      logic        cy;
   } mcountinhibit_t;

   typedef struct packed {
      logic                     trap_v;
      logic                     interrupt;
      logic                     eret;
      logic [vaddr_width_p-1:0] npc;
      priv_e                    priv_n;
   } trap_pkt_t;

   // RV64 with A, I, M and U
   localparam logic [xlen_p-1:0] misa_c    = 64'h8000_0000_0010_1101;
   localparam logic [xlen_p-1:0] marchid_c = 64'd13;
   localparam logic [xlen_p-1:0] mimpid_c  = 64'd1;

   // Lowest set bit wins; result is {valid, index}
   function automatic logic [4:0] prio_enc16(input logic [15:0] vec);
      logic [4:0] res;
      res = '0;
      for (int i = 15; i >= 0; i--)
      begin
         if (vec[i])
         begin
            res = {1'b1, 4'(i)};
         end
      end
      return res;
   endfunction

   // Set and clear with a zero operand leave the CSR untouched
   function automatic logic csr_op_writes(input csr_op_e op,
                                          input logic [xlen_p-1:0] operand);
      return (op == op_rw) || (op == op_rwi) || (operand != '0);
   endfunction

endpackage

// ==== verilog/csr_if.sv ====
`timescale 1ns/10ps

interface csr_dec_if
   import csr_pkg::*;
();

   logic              valid;
   cmd_kind_e         kind;
   csr_op_e           op;
   csr_addr_t         addr;
   logic [xlen_p-1:0] wdata;
   logic              illegal;
   priv_e             priv;

   modport master (
      output valid, kind, op, addr, wdata, illegal,
      input  priv
   );

   modport slave (
      input  valid, kind, op, addr, wdata, illegal,
      output priv
   );

endinterface

interface csr_wb_if
   import csr_pkg::*;
();

   logic              valid;
   logic [xlen_p-1:0] rdata;
   logic              illegal;
   trap_pkt_t         trap;

   modport master (output valid, rdata, illegal, trap);

   modport slave (input valid, rdata, illegal, trap);

endinterface

// ==== verilog/csr_decode.sv ====
`timescale 1ns/10ps

module csr_decode
   import csr_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              cmd_v_i,
   input  csr_op_e           cmd_op_i,
   input  csr_addr_t         cmd_addr_i,
   input  logic [xlen_p-1:0] cmd_data_i,
   csr_dec_if.master         dec
);

   cmd_kind_e         kind;
   logic [xlen_p-1:0] operand;
   logic              addr_known;
   logic              addr_priv_bad;
   logic              addr_ro;
   logic              wr_req;
   logic              illegal;

   always_comb
   begin
      case (cmd_op_i)
         op_rw, op_rs, op_rc, op_rwi, op_rsi, op_rci: kind = kind_access;
         op_mret:     kind = kind_mret;
         op_take_irq: kind = kind_irq;
         default:     kind = kind_none;
      endcase
   end

   // Immediate forms carry a zero-extended 5-bit value
   assign operand = (cmd_op_i inside {op_rwi, op_rsi, op_rci})
                    ? xlen_p'(cmd_data_i[4:0]) : cmd_data_i;

   assign addr_known = cmd_addr_i inside {
      csr_mstatus_c, csr_misa_c, csr_mie_c, csr_mtvec_c, csr_mcountinhibit_c,
      csr_mscratch_c, csr_mepc_c, csr_mcause_c, csr_mtval_c, csr_mip_c,
      csr_mcycle_c, csr_minstret_c, csr_mvendorid_c, csr_marchid_c,
      csr_mimpid_c, csr_mhartid_c
   };

   // Address bits 9:8 give the lowest privilege allowed
   assign addr_priv_bad = cmd_addr_i[9:8] > 2'(dec.priv);
   assign addr_ro       = cmd_addr_i[11:10] == 2'b11;
   assign wr_req        = csr_op_writes(cmd_op_i, operand);

   always_comb
   begin
      case (kind)
         kind_access: illegal = !addr_known || addr_priv_bad || (addr_ro && wr_req);
         kind_mret:   illegal = dec.priv == priv_u;
         kind_irq:    illegal = 1'b0;
         default:     illegal = 1'b1;
      endcase
   end

   assign dec.valid   = cmd_v_i;
   assign dec.kind    = kind;
   assign dec.op      = cmd_op_i;
   assign dec.addr    = cmd_addr_i;
   assign dec.wdata   = operand;
   assign dec.illegal = illegal;

   // Core only issues defined operations
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cmd_v_i |-> kind != kind_none);

endmodule

// ==== verilog/csr_trap_ctrl.sv ====
`timescale 1ns/10ps

module csr_trap_ctrl
   import csr_pkg::*;
(
   input  mstatus_t   mstatus_i,
   input  mie_t       mie_i,
   input  mip_t       mip_i,
   input  priv_e      priv_i,
   input  ecode_dec_t ecode_dec_i,
   output logic       irq_v_o,
   output logic [3:0] irq_code_o,
   output logic       exc_v_o,
   output logic [3:0] exc_code_o
);

   logic        gie;
   logic        msi_v;
   logic        mti_v;
   logic        mei_v;
   logic [15:0] irq_dec;

   // U mode can always be interrupted
   assign gie = mstatus_i.mie || (priv_i == priv_u);

   assign msi_v = mie_i.msie & mip_i.msip;
   assign mti_v = mie_i.mtie & mip_i.mtip;
   assign mei_v = mie_i.meie & mip_i.meip;

   // Same bit positions as the mcause codes
   assign irq_dec = {4'b0, mei_v, 3'b0, mti_v, 3'b0, msi_v, 3'b0} & {16{gie}};

   assign {irq_v_o, irq_code_o} = prio_enc16(irq_dec);
   assign {exc_v_o, exc_code_o} = prio_enc16(ecode_dec_i);

endmodule

// ==== verilog/csr_execute.sv ====
`timescale 1ns/10ps

module csr_execute
   import csr_pkg::*;
#(
   parameter logic [xlen_p-1:0] hart_id_p   = '0,
   parameter logic [xlen_p-1:0] reset_vec_p = '0
)
(
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   csr_dec_if.slave                 dec,
   csr_wb_if.master                 wb,
   input  logic                     exception_v_i,
   input  logic [vaddr_width_p-1:0] exception_pc_i,
   input  logic [vaddr_width_p-1:0] exception_vaddr_i,
   input  ecode_dec_t               exception_ecode_dec_i,
   input  logic                     instret_i,
   input  logic                     timer_irq_i,
   input  logic                     software_irq_i,
   input  logic                     external_irq_i,
   output logic                     accept_irq_o
);

   priv_e             priv_r, priv_n;
   mstatus_t          mstatus_r, mstatus_n;
   mie_t              mie_r, mie_n;
   mip_t              mip_r, mip_n;
   mcause_t           mcause_r, mcause_n;
   mcountinhibit_t    mcountinhibit_r, mcountinhibit_n;
   logic [xlen_p-1:0] mtvec_r, mtvec_n;
   logic [xlen_p-1:0] mscratch_r, mscratch_n;
   logic [xlen_p-1:0] mepc_r, mepc_n;
   logic [xlen_p-1:0] mtval_r, mtval_n;
   logic [xlen_p-1:0] mcycle_r, mcycle_n;
   logic [xlen_p-1:0] minstret_r, minstret_n;

   logic [xlen_p-1:0] csr_rdata;
   logic [xlen_p-1:0] csr_wdata;
   mstatus_t          wr_status;
   mie_t              wr_ie;
   mcause_t           wr_cause;
   mcountinhibit_t    wr_inhibit;

   logic              irq_v;
   logic [3:0]        irq_code;
   logic              exc_v;
   logic [3:0]        exc_code;
   logic              cmd_ok;
   logic              exc_take;
   logic              irq_take;
   logic              ret_take;
   logic              wr_take;

   csr_trap_ctrl trap_ctrl_i (
      .mstatus_i   (mstatus_r),
      .mie_i       (mie_r),
      .mip_i       (mip_r),
      .priv_i      (priv_r),
      .ecode_dec_i (exception_ecode_dec_i),
      .irq_v_o     (irq_v),
      .irq_code_o  (irq_code),
      .exc_v_o     (exc_v),
      .exc_code_o  (exc_code)
   );

   assign cmd_ok   = dec.valid & ~dec.illegal;
   assign exc_take = exception_v_i & exc_v;
   assign irq_take = cmd_ok & (dec.kind == kind_irq) & irq_v;
   assign ret_take = cmd_ok & (dec.kind == kind_mret);
   assign wr_take  = cmd_ok & (dec.kind == kind_access) & csr_op_writes(dec.op, dec.wdata);

   always_comb
   begin
      case (dec.addr)
         csr_mstatus_c:       csr_rdata = mstatus_r;
         csr_misa_c:          csr_rdata = misa_c;
         csr_mie_c:           csr_rdata = mie_r;
         csr_mtvec_c:         csr_rdata = mtvec_r;
         csr_mcountinhibit_c: csr_rdata = mcountinhibit_r;
         csr_mscratch_c:      csr_rdata = mscratch_r;
         csr_mepc_c:          csr_rdata = mepc_r;
         csr_mcause_c:        csr_rdata = mcause_r;
         csr_mtval_c:         csr_rdata = mtval_r;
         csr_mip_c:           csr_rdata = mip_r;
         csr_mcycle_c:        csr_rdata = mcycle_r;
         csr_minstret_c:      csr_rdata = minstret_r;
         csr_marchid_c:       csr_rdata = marchid_c;
         csr_mimpid_c:        csr_rdata = mimpid_c;
         csr_mhartid_c:       csr_rdata = hart_id_p;
         default:             csr_rdata = '0;
      endcase
   end

   always_comb
   begin
      case (dec.op)
         op_rs, op_rsi: csr_wdata = csr_rdata | dec.wdata;
         op_rc, op_rci: csr_wdata = csr_rdata & ~dec.wdata;
         default:       csr_wdata = dec.wdata;
      endcase
   end

   assign wr_status  = mstatus_t'(csr_wdata);
   assign wr_ie      = mie_t'(csr_wdata);
   assign wr_cause   = mcause_t'(csr_wdata);
   assign wr_inhibit = mcountinhibit_t'(csr_wdata);

   always_comb
   begin
      priv_n          = priv_r;
      mstatus_n       = mstatus_r;
      mie_n           = mie_r;
      mcause_n        = mcause_r;
      mcountinhibit_n = mcountinhibit_r;
      mtvec_n         = mtvec_r;
      mscratch_n      = mscratch_r;
      mepc_n          = mepc_r;
      mtval_n         = mtval_r;
      mcycle_n        = mcountinhibit_r.cy ? mcycle_r : mcycle_r + xlen_p'(1);
      minstret_n      = mcountinhibit_r.ir ? minstret_r : minstret_r + xlen_p'(instret_i);

      // Pending bits follow the interrupt lines
      mip_n      = '0;
      mip_n.msip = software_irq_i;
      mip_n.mtip = timer_irq_i;
      mip_n.meip = external_irq_i;

      if (exc_take || irq_take)
      begin
         priv_n             = priv_m;
         mstatus_n.mpp      = priv_r;
         mstatus_n.mpie     = mstatus_r.mie;
         mstatus_n.mie      = 1'b0;
         mepc_n             = xlen_p'($signed(exception_pc_i));
         mcause_n           = '0;
         mcause_n.interrupt = irq_take;
         mcause_n.ecode     = irq_take ? irq_code : exc_code;
         mtval_n            = irq_take ? '0 : xlen_p'($signed(exception_vaddr_i));
      end
      else if (ret_take)
      begin
         priv_n         = mstatus_r.mpp;
         mstatus_n.mpp  = priv_u;
         mstatus_n.mpie = 1'b1;
         mstatus_n.mie  = mstatus_r.mpie;
      end
      else if (wr_take)
      begin
         case (dec.addr)
            csr_mstatus_c:
            begin
               mstatus_n      = '{mpp: priv_u, default: '0};
               mstatus_n.mie  = wr_status.mie;
               mstatus_n.mpie = wr_status.mpie;
               // Only M and U exist
               mstatus_n.mpp  = (wr_status.mpp == priv_m) ? priv_m : priv_u;
            end
            csr_mie_c:
               mie_n = '{msie: wr_ie.msie, mtie: wr_ie.mtie, meie: wr_ie.meie, default: '0};
            csr_mtvec_c:    mtvec_n    = csr_wdata;
            csr_mscratch_c: mscratch_n = csr_wdata;
            csr_mepc_c:     mepc_n     = csr_wdata;
            csr_mcause_c:
               mcause_n = '{interrupt: wr_cause.interrupt, ecode: wr_cause.ecode, default: '0};
            csr_mtval_c:    mtval_n    = csr_wdata;
            csr_mcycle_c:   mcycle_n   = csr_wdata;
            csr_minstret_c: minstret_n = csr_wdata;
            csr_mcountinhibit_c:
               mcountinhibit_n = '{cy: wr_inhibit.cy, ir: wr_inhibit.ir, default: '0};
            default:
            begin
               mtvec_n = mtvec_r;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         priv_r          <= priv_m;
         mstatus_r       <= '{mpp: priv_u, default: '0};
         mie_r           <= '0;
         mip_r           <= '0;
         mcause_r        <= '0;
         mcountinhibit_r <= '0;
         mtvec_r         <= reset_vec_p;
         mscratch_r      <= '0;
         mepc_r          <= '0;
         mtval_r         <= '0;
         mcycle_r        <= '0;
         minstret_r      <= '0;
      end
      else
      begin
         priv_r          <= priv_n;
         mstatus_r       <= mstatus_n;
         mie_r           <= mie_n;
         mip_r           <= mip_n;
         mcause_r        <= mcause_n;
         mcountinhibit_r <= mcountinhibit_n;
         mtvec_r         <= mtvec_n;
         mscratch_r      <= mscratch_n;
         mepc_r          <= mepc_n;
         mtval_r         <= mtval_n;
         mcycle_r        <= mcycle_n;
         minstret_r      <= minstret_n;
      end
   end

   assign accept_irq_o = irq_v;
   assign dec.priv     = priv_r;

   // Read data is the value before this command's write
   assign wb.valid   = dec.valid;
   assign wb.rdata   = csr_rdata;
   assign wb.illegal = dec.valid & dec.illegal;
   assign wb.trap    = '{trap_v:    exc_take,
                         interrupt: irq_take,
                         eret:      ret_take,
                         npc:       ret_take ? mepc_r[vaddr_width_p-1:0]
                                             : mtvec_r[vaddr_width_p-1:0],
                         priv_n:    priv_n};

   // Core keeps commands and exceptions apart
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(dec.valid && exception_v_i));

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0({wb.trap.trap_v, wb.trap.interrupt, wb.trap.eret}));

endmodule

// ==== verilog/csr_result.sv ====
`timescale 1ns/10ps

module csr_result
   import csr_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   csr_wb_if.slave                  wb,
   output logic                     v_o,
   output logic [xlen_p-1:0]        data_o,
   output logic                     illegal_instr_o,
   output logic                     trap_v_o,
   output logic                     trap_interrupt_o,
   output logic                     eret_o,
   output logic [vaddr_width_p-1:0] trap_npc_o,
   output priv_e                    priv_mode_o
);

   logic priv_upd;

   assign priv_upd = wb.trap.trap_v | wb.trap.interrupt | wb.trap.eret;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         v_o              <= 1'b0;
         illegal_instr_o  <= 1'b0;
         trap_v_o         <= 1'b0;
         trap_interrupt_o <= 1'b0;
         eret_o           <= 1'b0;
         priv_mode_o      <= priv_m;
      end
      else
      begin
         v_o              <= wb.valid;
         illegal_instr_o  <= wb.illegal;
         trap_v_o         <= wb.trap.trap_v;
         trap_interrupt_o <= wb.trap.interrupt;
         eret_o           <= wb.trap.eret;
         if (priv_upd)
         begin
            priv_mode_o <= wb.trap.priv_n;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      data_o     <= wb.rdata;
      trap_npc_o <= wb.trap.npc;
   end

endmodule

// ==== verilog/csr_unit.sv ====
`timescale 1ns/10ps

module csr_unit
   import csr_pkg::*;
#(
   parameter logic [xlen_p-1:0] hart_id_p   = '0,
   parameter logic [xlen_p-1:0] reset_vec_p = '0
)
(
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  logic                     cmd_v_i,
   input  csr_op_e                  cmd_op_i,
   input  csr_addr_t                cmd_addr_i,
   input  logic [xlen_p-1:0]        cmd_data_i,
   input  logic                     exception_v_i,
   input  logic [vaddr_width_p-1:0] exception_pc_i,
   input  logic [vaddr_width_p-1:0] exception_vaddr_i,
   input  ecode_dec_t               exception_ecode_dec_i,
   input  logic                     instret_i,
   input  logic                     timer_irq_i,
   input  logic                     software_irq_i,
   input  logic                     external_irq_i,
   output logic                     accept_irq_o,
   output logic                     v_o,
   output logic [xlen_p-1:0]        data_o,
   output logic                     illegal_instr_o,
   output logic                     trap_v_o,
   output logic                     trap_interrupt_o,
   output logic                     eret_o,
   output logic [vaddr_width_p-1:0] trap_npc_o,
   output priv_e                    priv_mode_o
);

   csr_dec_if dec_bus ();
   csr_wb_if  wb_bus ();

   csr_decode decode_i (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .cmd_v_i    (cmd_v_i),
      .cmd_op_i   (cmd_op_i),
      .cmd_addr_i (cmd_addr_i),
      .cmd_data_i (cmd_data_i),
      .dec        (dec_bus)
   );

   csr_execute #(
      .hart_id_p   (hart_id_p),
      .reset_vec_p (reset_vec_p)
   ) execute_i (
      .clk_i                 (clk_i),
      .rst_n_i               (rst_n_i),
      .dec                   (dec_bus),
      .wb                    (wb_bus),
      .exception_v_i         (exception_v_i),
      .exception_pc_i        (exception_pc_i),
      .exception_vaddr_i     (exception_vaddr_i),
      .exception_ecode_dec_i (exception_ecode_dec_i),
      .instret_i             (instret_i),
      .timer_irq_i           (timer_irq_i),
      .software_irq_i        (software_irq_i),
      .external_irq_i        (external_irq_i),
      .accept_irq_o          (accept_irq_o)
   );

   csr_result result_i (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .wb               (wb_bus),
      .v_o              (v_o),
      .data_o           (data_o),
      .illegal_instr_o  (illegal_instr_o),
      .trap_v_o         (trap_v_o),
      .trap_interrupt_o (trap_interrupt_o),
      .eret_o           (eret_o),
      .trap_npc_o       (trap_npc_o),
      .priv_mode_o      (priv_mode_o)
   );

endmodule

// ==== include/csr_tb_tasks.svh ====
`ifndef CSR_TB_TASKS_SVH
`define CSR_TB_TASKS_SVH

   function automatic logic [xlen_p-1:0] random64();
      return {$urandom, $urandom};
   endfunction

   // Top address bit kept low so the value zero-extends
   function automatic logic [vaddr_width_p-1:0] random_vaddr();
      logic [vaddr_width_p-1:0] va;
      va                  = vaddr_width_p'(random64());
      va[vaddr_width_p-1] = 1'b0;
      return va;
   endfunction

   // Timer interrupt is taken when enabled, pending and globally allowed
   function automatic logic accept_rule(input priv_e mode, input logic status_mie,
                                        input logic mtie, input logic mtip);
      return mtie && mtip && (status_mie || mode == priv_u);
   endfunction

   task automatic check_data(input string name, input logic [xlen_p-1:0] got,
                             input logic [xlen_p-1:0] exp);
      if (got !== exp)
      begin
         $display("error %s: got 0x%016h, expected 0x%016h", name, got, exp);
         stop_on_failure();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
         stop_on_failure();
      end
   endtask

   task automatic check_priv(input string name, input priv_e got, input priv_e exp);
      if (got !== exp)
      begin
         $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
         stop_on_failure();
      end
   endtask

   task automatic check_trap(input logic exp_v, input logic exp_irq, input logic exp_eret,
                             input logic [vaddr_width_p-1:0] exp_npc);
      check_bit("trap_v_o", trap_v, exp_v);
      check_bit("trap_interrupt_o", trap_interrupt, exp_irq);
      check_bit("eret_o", eret, exp_eret);
      if ((exp_v || exp_irq || exp_eret) && (trap_npc !== exp_npc))
      begin
         $display("error trap_npc_o: got 0x%010h, expected 0x%010h", trap_npc, exp_npc);
         stop_on_failure();
      end
   endtask

   task automatic wait_response();
      int cycles;
      cycles = 0;
      while (!(rsp_v || trap_v))
      begin
         if (cycles == timeout_c)
         begin
            $display("timeout: no result from the DUT after %0d cycles", timeout_c);
            stop_on_failure();
         end
         @(negedge clk);
         cycles++;
      end
   endtask

   task automatic run_cmd(input csr_op_e op, input csr_addr_t addr,
                          input logic [xlen_p-1:0] wdata);
      @(negedge clk);
      cmd_v    = 1'b1;
      cmd_op   = op;
      cmd_addr = addr;
      cmd_data = wdata;
      @(negedge clk);
      cmd_v = 1'b0;
      wait_response();
      check_bit("v_o", rsp_v, 1'b1);
   endtask

   task automatic run_exception(input logic [vaddr_width_p-1:0] pc,
                                input logic [vaddr_width_p-1:0] va,
                                input ecode_dec_t causes);
      @(negedge clk);
      exception_v     = 1'b1;
      exception_pc    = pc;
      exception_vaddr = va;
      exception_ecode = causes;
      @(negedge clk);
      exception_v     = 1'b0;
      exception_ecode = '0;
      wait_response();
      check_bit("v_o", rsp_v, 1'b0);
   endtask

   task automatic csr_apply(input csr_op_e op, input csr_addr_t addr,
                            input logic [xlen_p-1:0] wdata);
      run_cmd(op, addr, wdata);
      check_bit("illegal_instr_o", illegal_instr, 1'b0);
   endtask

   // Result of every access is the value before the write
   task automatic csr_access(input csr_op_e op, input csr_addr_t addr,
                             input logic [xlen_p-1:0] wdata,
                             input logic [xlen_p-1:0] exp_old);
      csr_apply(op, addr, wdata);
      check_data("data_o", rsp_data, exp_old);
   endtask

   task automatic check_illegal(input csr_op_e op, input csr_addr_t addr,
                                input logic [xlen_p-1:0] wdata);
      run_cmd(op, addr, wdata);
      check_bit("illegal_instr_o", illegal_instr, 1'b1);
   endtask

   task automatic pulse_instret(input int count);
      repeat (count)
      begin
         @(negedge clk);
         instret = 1'b1;
         @(negedge clk);
         instret = 1'b0;
      end
   endtask

`endif

// ==== verification/csr_unit_tb.sv ====
`timescale 1ns/10ps

module csr_unit_tb
   import csr_pkg::*;
#(
   parameter int unsigned seed_p = 64116
);

   localparam logic [xlen_p-1:0] hart_id_c   = 64'h0000_0000_0000_0003;
   localparam logic [xlen_p-1:0] reset_vec_c = 64'h0000_0000_8000_0000;
   localparam int                timeout_c   = 20;

   logic                     clk;
   logic                     rst_n;
   logic                     cmd_v;
   csr_op_e                  cmd_op;
   csr_addr_t                cmd_addr;
   logic [xlen_p-1:0]        cmd_data;
   logic                     exception_v;
   logic [vaddr_width_p-1:0] exception_pc;
   logic [vaddr_width_p-1:0] exception_vaddr;
   ecode_dec_t               exception_ecode;
   logic                     instret;
   logic                     timer_irq;
   logic                     software_irq;
   logic                     external_irq;
   logic                     accept_irq;
   logic                     rsp_v;
   logic [xlen_p-1:0]        rsp_data;
   logic                     illegal_instr;
   logic                     trap_v;
   logic                     trap_interrupt;
   logic                     eret;
   logic [vaddr_width_p-1:0] trap_npc;
   priv_e                    priv_mode;

   // Expected mtvec, shared by the trap tests
   logic [xlen_p-1:0]        mtvec_model;

   csr_unit #(
      .hart_id_p   (hart_id_c),
      .reset_vec_p (reset_vec_c)
   ) dut_i (
      .clk_i                 (clk),
      .rst_n_i               (rst_n),
      .cmd_v_i               (cmd_v),
      .cmd_op_i              (cmd_op),
      .cmd_addr_i            (cmd_addr),
      .cmd_data_i            (cmd_data),
      .exception_v_i         (exception_v),
      .exception_pc_i        (exception_pc),
      .exception_vaddr_i     (exception_vaddr),
      .exception_ecode_dec_i (exception_ecode),
      .instret_i             (instret),
      .timer_irq_i           (timer_irq),
      .software_irq_i        (software_irq),
      .external_irq_i        (external_irq),
      .accept_irq_o          (accept_irq),
      .v_o                   (rsp_v),
      .data_o                (rsp_data),
      .illegal_instr_o       (illegal_instr),
      .trap_v_o              (trap_v),
      .trap_interrupt_o      (trap_interrupt),
      .eret_o                (eret),
      .trap_npc_o            (trap_npc),
      .priv_mode_o           (priv_mode)
   );

   always #10 clk = ~clk;

   task automatic stop_on_failure();
      $display("Result: FAILED");
      $fatal(1);
   endtask

`include "csr_tb_tasks.svh"

   task automatic test_rmw();
      logic [xlen_p-1:0] model;
      logic [xlen_p-1:0] operand;
      model   = '0;
      operand = random64();
      csr_access(op_rw, csr_mscratch_c, operand, model);
      model   = operand;
      operand = random64();
      csr_access(op_rs, csr_mscratch_c, operand, model);
      model   = model | operand;
      operand = random64();
      csr_access(op_rc, csr_mscratch_c, operand, model);
      model   = model & ~operand;
      // Immediate forms only see the low 5 bits
      operand = random64();
      csr_access(op_rsi, csr_mscratch_c, operand, model);
      model   = model | xlen_p'(operand[4:0]);
      operand = random64();
      csr_access(op_rci, csr_mscratch_c, operand, model);
      model   = model & ~xlen_p'(operand[4:0]);
      operand = random64();
      csr_access(op_rwi, csr_mscratch_c, operand, model);
      model   = xlen_p'(operand[4:0]);
      csr_access(op_rs, csr_mscratch_c, '0, model);
   endtask

   task automatic test_fixed_values();
      csr_access(op_rs, csr_mhartid_c, '0, hart_id_c);
      csr_access(op_rs, csr_misa_c, '0, 64'h8000_0000_0010_1101);
      csr_access(op_rs, csr_marchid_c, '0, 64'd13);
      csr_access(op_rs, csr_mimpid_c, '0, 64'd1);
      csr_access(op_rs, csr_mvendorid_c, '0, 64'd0);
      check_illegal(op_rw, csr_mhartid_c, random64());
      check_illegal(op_rs, 12'h7c0, '0);
   endtask

   task automatic test_exception();
      logic [vaddr_width_p-1:0] pc;
      logic [vaddr_width_p-1:0] va;
      mtvec_model       = random64();
      mtvec_model[1:0]  = 2'b00;
      csr_access(op_rw, csr_mtvec_c, mtvec_model, reset_vec_c);
      pc = random_vaddr();
      va = random_vaddr();
      run_exception(pc, va, 16'h0004);
      check_trap(1'b1, 1'b0, 1'b0, mtvec_model[vaddr_width_p-1:0]);
      check_priv("priv_mode_o", priv_mode, priv_m);
      csr_access(op_rs, csr_mepc_c, '0, xlen_p'(pc));
      csr_access(op_rs, csr_mcause_c, '0, 64'd2);
      csr_access(op_rs, csr_mtval_c, '0, xlen_p'(va));
      // Causes 5 and 13 together
      run_exception(pc, va, 16'h2020);
      check_trap(1'b1, 1'b0, 1'b0, mtvec_model[vaddr_width_p-1:0]);
      csr_access(op_rs, csr_mcause_c, '0, 64'd5);
   endtask

   task automatic test_mret();
      logic [xlen_p-1:0] epc;
      epc = xlen_p'(random_vaddr());
      csr_apply(op_rw, csr_mepc_c, epc);
      // mpp is U, mpie is set
      csr_apply(op_rw, csr_mstatus_c, 64'h0000_0000_0000_0080);
      run_cmd(op_mret, '0, '0);
      check_bit("illegal_instr_o", illegal_instr, 1'b0);
      check_trap(1'b0, 1'b0, 1'b1, epc[vaddr_width_p-1:0]);
      check_priv("priv_mode_o", priv_mode, priv_u);
      check_illegal(op_rs, csr_mscratch_c, '0);
      check_illegal(op_mret, '0, '0);
      check_trap(1'b0, 1'b0, 1'b0, '0);
      check_priv("priv_mode_o", priv_mode, priv_u);
   endtask

   task automatic test_interrupts();
      logic [vaddr_width_p-1:0] pc;
      pc = random_vaddr();
      // Back to M with mpp at U and mpie set
      run_exception(pc, '0, 16'h0004);
      check_priv("priv_mode_o", priv_mode, priv_m);
      timer_irq = 1'b1;
      csr_apply(op_rw, csr_mie_c, 64'h0000_0000_0000_0080);
      check_bit("accept_irq_o", accept_irq, accept_rule(priv_m, 1'b0, 1'b1, 1'b1));
      csr_apply(op_rsi, csr_mstatus_c, 64'h8);
      check_bit("accept_irq_o", accept_irq, accept_rule(priv_m, 1'b1, 1'b1, 1'b1));
      csr_apply(op_rci, csr_mstatus_c, 64'h8);
      check_bit("accept_irq_o", accept_irq, accept_rule(priv_m, 1'b0, 1'b1, 1'b1));
      // Clear mpie so U mode runs with mstatus.mie low
      csr_apply(op_rc, csr_mstatus_c, 64'h0000_0000_0000_0080);
      run_cmd(op_mret, '0, '0);
      check_trap(1'b0, 1'b0, 1'b1, pc);
      check_priv("priv_mode_o", priv_mode, priv_u);
      check_bit("accept_irq_o", accept_irq, accept_rule(priv_u, 1'b0, 1'b1, 1'b1));
      run_cmd(op_take_irq, '0, '0);
      check_bit("illegal_instr_o", illegal_instr, 1'b0);
      check_trap(1'b0, 1'b1, 1'b0, mtvec_model[vaddr_width_p-1:0]);
      check_priv("priv_mode_o", priv_mode, priv_m);
      check_bit("accept_irq_o", accept_irq, accept_rule(priv_m, 1'b0, 1'b1, 1'b1));
      timer_irq = 1'b0;
      csr_access(op_rs, csr_mcause_c, '0, 64'h8000_0000_0000_0007);
   endtask

   task automatic test_counters();
      logic [xlen_p-1:0] base;
      logic [xlen_p-1:0] cycle_base;
      // Inhibit both cy and ir
      csr_apply(op_rw, csr_mcountinhibit_c, 64'h5);
      cycle_base = random64();
      csr_apply(op_rw, csr_mcycle_c, cycle_base);
      csr_access(op_rs, csr_mcycle_c, '0, cycle_base);
      base = xlen_p'($urandom);
      csr_apply(op_rw, csr_minstret_c, base);
      pulse_instret(3);
      csr_access(op_rs, csr_minstret_c, '0, base);
      csr_apply(op_rw, csr_mcountinhibit_c, '0);
      pulse_instret(5);
      csr_access(op_rs, csr_minstret_c, '0, base + 64'd5);
   endtask

   initial
   begin
      void'($urandom(seed_p));
      clk             = 1'b0;
      rst_n           = 1'b0;
      cmd_v           = 1'b0;
      cmd_op          = op_rw;
      cmd_addr        = '0;
      cmd_data        = '0;
      exception_v     = 1'b0;
      exception_pc    = '0;
      exception_vaddr = '0;
      exception_ecode = '0;
      instret         = 1'b0;
      timer_irq       = 1'b0;
      software_irq    = 1'b0;
      external_irq    = 1'b0;
      mtvec_model     = reset_vec_c;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      check_priv("priv_mode_o", priv_mode, priv_m);
      check_bit("v_o", rsp_v, 1'b0);
      check_trap(1'b0, 1'b0, 1'b0, '0);
      test_rmw();
      test_fixed_values();
      test_exception();
      test_mret();
      test_interrupts();
      test_counters();
      $display("Result: PASSED");
      $finish;
   end

endmodule

// ==== csr_unit.f ====
+incdir+include
verilog/csr_pkg.sv
verilog/csr_if.sv
verilog/csr_decode.sv
verilog/csr_trap_ctrl.sv
verilog/csr_execute.sv
verilog/csr_result.sv
verilog/csr_unit.sv
verification/csr_unit_tb.sv

// ==== Makefile ====
SIM    ?= verilator
TOP    ?= csr_unit_tb
SEED   ?= 64116
FLIST  ?= csr_unit.f
BUILD  ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM) from $(FLIST) and run $(TOP)"
	@echo "  clean  remove the build directory $(BUILD)"
	@echo "  help   show this list"
	@echo "Variables: SIM TOP SEED FLIST BUILD VFLAGS"

test:
	$(SIM) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Gseed_p=$(SEED) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
